// ==== alu_unit.f ====
+incdir+verilog
+incdir+tests
verilog/isa_pkg.sv
verilog/datapath_pkg.sv
verilog/adder_multifunc.sv
verilog/shifter.sv
verilog/alu.sv
verilog/exec_stage.sv
verilog/alu_unit.sv
tests/alu_unit_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= alu_unit_tb
FILELIST  ?= alu_unit.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tests/alu_ref.svh ====
// ALU reference model: expected result, flag values and flag write enables per opcode
`ifndef ALU_REF_SVH
`define ALU_REF_SVH

`include "alu_macros.svh"

function automatic int clamp_range(input int v, input int lo, input int hi);
    if (v > hi) return hi;
    if (v < lo) return lo;
    return v;
endfunction

function automatic logic [15:0] alu_ref_result(input logic [3:0] op, input logic [15:0] rs,
                                               input logic [15:0] rt);
    int          lane;
    int          i;
    logic [15:0] res;
    logic [31:0] wide;
    res = 16'h0000;
    case (op)
        OP_ADD, OP_LW, OP_SW:
            res = 16'(clamp_range(int'($signed(rs)) + int'($signed(rt)), -32768, 32767));
        OP_SUB:
            res = 16'(clamp_range(int'($signed(rs)) - int'($signed(rt)), -32768, 32767));
        OP_XOR: res = rs ^ rt;
        OP_RED: res = 16'(int'($signed(rs[15:8])) + int'($signed(rt[15:8]))
                          + int'($signed(rs[7:0])) + int'($signed(rt[7:0])));
        OP_SLL: res = rs << rt[3:0];
        OP_SRA: res = $signed(rs) >>> rt[3:0];
        OP_ROR: begin
            wide = {rs, rs} >> rt[3:0];  // Low half holds the rotated word
            res  = wide[15:0];
        end
        OP_PADDSB: begin
            for (i = 0; i < 4; i++) begin
                lane = int'($signed(rs[i*4 +: 4])) + int'($signed(rt[i*4 +: 4]));
                res[i*4 +: 4] = 4'(clamp_range(lane, -8, 7));
            end
        end
        OP_LLB: res = {rs[15:8], rt[7:0]};
        OP_LHB: res = {rt[7:0], rs[7:0]};
        default: res = `ALU_BAD_RESULT;
    endcase
    return res;
endfunction

// Flag values, zero where the opcode defines none
function automatic logic [2:0] alu_ref_flags(input logic [3:0] op, input logic [15:0] rs,
                                             input logic [15:0] rt);
    int          exact;
    logic [15:0] res;
    logic [2:0]  f;
    res   = alu_ref_result(op, rs, rt);
    f     = 3'b000;
    exact = (op == OP_SUB) ? int'($signed(rs)) - int'($signed(rt))
                           : int'($signed(rs)) + int'($signed(rt));
    case (op)
        OP_ADD, OP_SUB: begin
            f[FLAG_N] = res[15];
            f[FLAG_V] = (exact > 32767) || (exact < -32768);  // Saturation happened
            f[FLAG_Z] = (res == 16'h0000);
        end
        OP_XOR, OP_SLL, OP_SRA, OP_ROR: f[FLAG_Z] = (res == 16'h0000);
        default: f = 3'b000;
    endcase
    return f;
endfunction

function automatic logic [2:0] alu_ref_flag_we(input logic [3:0] op);
    logic [2:0] we;
    we = 3'b000;
    case (op)
        OP_ADD, OP_SUB: we = 3'b111;
        OP_XOR, OP_SLL, OP_SRA, OP_ROR: we[FLAG_Z] = 1'b1;
        default: we = 3'b000;
    endcase
    return we;
endfunction

`endif

// ==== tests/alu_unit_tb.sv ====
// Testbench for the execute block: directed corner cases and LFSR random run against a model
`timescale 1ns/1ps
`default_nettype none
`include "alu_macros.svh"

module alu_unit_tb import isa_pkg::*; ();

    logic        clk = 1'b0;
    logic        rst;
    logic        in_valid;
    alu_op_t     op;
    logic [15:0] rs;
    logic [15:0] rt;
    logic [15:0] rd;
    logic        out_valid;
    logic [2:0]  flags;

    logic [18:0] exp_q[$];             // {flags, rd} per strobe
    int          due_q[$];             // Cycle of the matching pulse
    int          cycle = 0;
    logic [2:0]  model_flags;
    logic [15:0] lfsr = 16'h0001;
    logic [15:0] held_rd = 16'h0000;   // Last expected values, reset state first
    logic [2:0]  held_flags = 3'b000;

    `include "alu_ref.svh"

    alu_unit UUT (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .op        (op),
        .rs        (rs),
        .rt        (rt),
        .rd        (rd),
        .out_valid (out_valid),
        .flags     (flags)
    );

    always #5 clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    task automatic fail_stop(input string msg);
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_mismatch(input string name, input logic [15:0] expv,
                                   input logic [15:0] actv);
        fail_stop($sformatf("FAIL at %0t: %s expected %h, actual %h", $time, name, expv, actv));
    endtask

    // Taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic random_bits(input int n, output logic [15:0] v);
        int i;
        v = 16'h0000;
        for (i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[14:0], lfsr[15]};
        end
    endtask

    // Strobe one item and record what the DUT must return for it
    task automatic apply_op(input logic [3:0] code, input logic [15:0] a, input logic [15:0] b);
        logic [2:0] we;
        logic [2:0] fv;
        op          = alu_op_t'(code);
        rs          = a;
        rt          = b;
        in_valid    = 1'b1;
        we          = alu_ref_flag_we(code);
        fv          = alu_ref_flags(code, a, b);
        model_flags = (model_flags & ~we) | (fv & we);
        exp_q.push_back({model_flags, alu_ref_result(code, a, b)});
        due_q.push_back(cycle + 1);
        @(posedge clk);
        #1;
    endtask

    task automatic idle_cycles(input int n);
        in_valid = 1'b0;
        repeat (n) @(posedge clk);
        #1;
    endtask

    always @(negedge clk) begin : compare
        logic [18:0] expv;
        int          due;
        if (!rst) begin
            if (out_valid) begin
                if (exp_q.size() == 0) begin
                    fail_stop("out_valid pulsed with no strobe outstanding");
                end else begin
                    expv = exp_q.pop_front();
                    due  = due_q.pop_front();
                    assert (cycle == due) else
                        fail_stop($sformatf("pulse in cycle %0d, due in cycle %0d", cycle, due));
                    assert (rd == expv[15:0]) else report_mismatch("rd", expv[15:0], rd);
                    assert (flags == expv[18:16]) else
                        report_mismatch("flags", 16'(expv[18:16]), 16'(flags));
                    held_rd    = expv[15:0];
                    held_flags = expv[18:16];
                end
            end else begin
                assert (due_q.size() == 0 || due_q[0] > cycle) else
                    fail_stop("out_valid missing in the cycle after a strobe");
                assert (rd == held_rd) else report_mismatch("rd", held_rd, rd);  // Must hold
                assert (flags == held_flags) else
                    report_mismatch("flags", 16'(held_flags), 16'(flags));
            end
        end
    end

    initial begin : stimulus
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] c;
        logic [15:0] g;
        int          sh;
        int          n;
        rst         = 1'b1;
        in_valid    = 1'b0;
        op          = OP_ADD;
        rs          = 16'h0000;
        rt          = 16'h0000;
        model_flags = 3'b000;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        idle_cycles(4);
        // Saturation, sign and zero cases
        apply_op(OP_ADD, 16'h7FFF, 16'h0001);
        apply_op(OP_SUB, 16'h8000, 16'h0001);
        apply_op(OP_ADD, 16'h8000, 16'h8000);
        apply_op(OP_SUB, 16'h7FFF, 16'hFFFF);
        apply_op(OP_ADD, 16'h1234, 16'hEDCC);
        apply_op(OP_SUB, 16'h5555, 16'h5555);
        apply_op(OP_ADD, 16'h0003, 16'hFFFB);
        idle_cycles(2);
        apply_op(OP_ADD, 16'h7FFF, 16'h0001);  // V set, then held below
        apply_op(OP_PADDSB, 16'h7777, 16'h1111);
        apply_op(OP_PADDSB, 16'h8888, 16'hF8F1);
        apply_op(OP_RED, 16'h7F80, 16'h7F80);
        apply_op(OP_RED, 16'h0102, 16'hFFFE);
        apply_op(OP_ADD, 16'h8000, 16'h8000);  // N and V set for the shifts
        for (sh = 0; sh < 16; sh++) begin
            apply_op(OP_SLL, 16'h9AC3, {12'hABC, 4'(sh)});
            apply_op(OP_SRA, 16'h9AC3, 16'(sh));
            apply_op(OP_ROR, 16'h9AC3, 16'(sh));
            apply_op(OP_SLL, 16'h3A5C, 16'(sh));
            apply_op(OP_SRA, 16'h3A5C, {12'h5A5, 4'(sh)});
            apply_op(OP_ROR, 16'h3A5C, 16'(sh));
        end
        apply_op(OP_SLL, 16'h8000, 16'h0001);
        apply_op(OP_XOR, 16'hA5A5, 16'hA5A5);
        apply_op(OP_XOR, 16'hA5A5, 16'h0F0F);
        idle_cycles(3);
        apply_op(OP_LLB, 16'h1234, 16'hABCD);
        apply_op(OP_LHB, 16'h1234, 16'hABCD);
        apply_op(OP_LW, 16'h7FF0, 16'h0020);
        apply_op(OP_SW, 16'h1000, 16'hFFFC);
        for (n = 12; n < 16; n++) begin
            apply_op(4'(n), 16'h0000, 16'h0000);
        end
        idle_cycles(2);
        for (n = 0; n < 2000; n++) begin
            random_bits(4, c);
            random_bits(16, a);
            random_bits(16, b);
            apply_op(c[3:0], a, b);
            random_bits(1, g);
            if (g[0]) idle_cycles(1);
        end
        in_valid = 1'b0;
        for (n = 0; n < 20 && exp_q.size() != 0; n++) begin
            @(posedge clk);
        end
        if (exp_q.size() == 0) begin
            $display("Testbench passed");
            $finish;
        end else begin
            fail_stop("timed out waiting for the last results");
        end
    end

endmodule

`default_nettype wire

// ==== verilog/alu_unit.sv ====
// Execute block top: combinational ALU followed by the execute stage register
`timescale 1ns/1ps
`default_nettype none
`include "alu_macros.svh"

module alu_unit import isa_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   in_valid,
    input  alu_op_t                op,
    input  logic [`ALU_WORD_W-1:0] rs,
    input  logic [`ALU_WORD_W-1:0] rt,
    output logic [`ALU_WORD_W-1:0] rd,
    output logic                   out_valid,
    output logic [2:0]             flags
);

    logic [`ALU_WORD_W-1:0] alu_result;
    logic [2:0]             alu_flags;    // Flag values, zero where undefined
    logic [2:0]             alu_flag_we;  // Flags this opcode writes

    alu u_alu (
        .op      (op),
        .rs      (rs),
        .rt      (rt),
        .rd      (alu_result),
        .flags   (alu_flags),
        .flag_we (alu_flag_we)
    );

    exec_stage u_exec (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .result    (alu_result),
        .flags_in  (alu_flags),
        .flag_we   (alu_flag_we),
        .rd        (rd),
        .out_valid (out_valid),
        .flags     (flags)
    );

endmodule

`default_nettype wire

// ==== verilog/exec_stage.sv ====
// Execute stage register: result with valid pulse and the N, V, Z flag register
`timescale 1ns/1ps
`default_nettype none
`include "alu_macros.svh"

module exec_stage import isa_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   in_valid,
    input  logic [`ALU_WORD_W-1:0] result,
    input  logic [2:0]             flags_in,
    input  logic [2:0]             flag_we,
    output logic [`ALU_WORD_W-1:0] rd,
    output logic                   out_valid,
    output logic [2:0]             flags
);

    always_ff @(posedge clk) begin
        if (rst) begin
            rd        <= '0;
            out_valid <= 1'b0;
            flags     <= 3'b000;
        end else begin
            out_valid <= in_valid;  // One pulse per strobe
            if (in_valid) begin
                rd <= result;  // Holds between strobes
            end
            // Each flag written only by the opcodes that define it
            if (in_valid && flag_we[FLAG_N]) begin
                flags[FLAG_N] <= flags_in[FLAG_N];
            end
            if (in_valid && flag_we[FLAG_V]) begin
                flags[FLAG_V] <= flags_in[FLAG_V];
            end
            if (in_valid && flag_we[FLAG_Z]) begin
                flags[FLAG_Z] <= flags_in[FLAG_Z];
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/alu.sv ====
// 16-bit ALU: opcode decode, functional units, result and flag selection
`timescale 1ns/1ps
`default_nettype none
`include "alu_macros.svh"

module alu import isa_pkg::*, datapath_pkg::*; (
    input  alu_op_t                op,
    input  logic [`ALU_WORD_W-1:0] rs,
    input  logic [`ALU_WORD_W-1:0] rt,
    output logic [`ALU_WORD_W-1:0] rd,
    output logic [2:0]             flags,
    output logic [2:0]             flag_we
);
    localparam int W  = `ALU_WORD_W;
    localparam int BW = `ALU_BYTE_W;

    adder_mode_t  adder_mode;
    shift_mode_t  shift_mode;
    logic [W-1:0] adder_out;
    logic         ovfl;
    logic [W-1:0] shift_out;
    logic [W-1:0] xor_out;
    logic [W-1:0] llb_out;
    logic [W-1:0] lhb_out;
    logic         rd_zero;

    adder_multifunc u_adder (
        .a    (rs),
        .b    (rt),
        .mode (adder_mode),
        .s    (adder_out),
        .ovfl (ovfl)
    );

    shifter u_shifter (
        .shift_in  (rs),
        .shamt     (rt[`ALU_SHAMT_W-1:0]),
        .mode      (shift_mode),
        .shift_out (shift_out)
    );

    assign xor_out = rs ^ rt;
    assign llb_out = {rs[W-1:BW], rt[BW-1:0]};  // Replace low byte
    assign lhb_out = {rt[BW-1:0], rs[BW-1:0]};  // Replace high byte

    always_comb begin
        case (op)
            OP_SUB:    adder_mode = SUB_SAT;
            OP_RED:    adder_mode = RED_BYTE;
            OP_PADDSB: adder_mode = PADD_NIBBLE;
            default:   adder_mode = ADD_SAT;  // ADD, LW, SW
        endcase
    end

    always_comb begin
        case (op)
            OP_SRA:  shift_mode = SH_SRA;
            OP_ROR:  shift_mode = SH_ROR;
            default: shift_mode = SH_SLL;
        endcase
    end

    always_comb begin
        case (op)
            OP_ADD, OP_SUB, OP_RED, OP_PADDSB, OP_LW, OP_SW: rd = adder_out;
            OP_XOR:                                          rd = xor_out;
            OP_SLL, OP_SRA, OP_ROR:                          rd = shift_out;
            OP_LLB:                                          rd = llb_out;
            OP_LHB:                                          rd = lhb_out;
            default:                                         rd = `ALU_BAD_RESULT;
        endcase
    end

    assign rd_zero = (rd == '0);

    // Undefined flags read as zero and are never written
    always_comb begin
        flags   = 3'b000;
        flag_we = 3'b000;
        case (op)
            OP_ADD, OP_SUB: begin
                flags[FLAG_N]   = rd[W-1];
                flags[FLAG_V]   = ovfl;
                flags[FLAG_Z]   = rd_zero;
                flag_we         = 3'b111;
            end
            OP_XOR, OP_SLL, OP_SRA, OP_ROR: begin
                flags[FLAG_Z]   = rd_zero;
                flag_we[FLAG_Z] = 1'b1;  // N and V hold
            end
            default: begin
                flags   = 3'b000;
                flag_we = 3'b000;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/shifter.sv ====
// Logarithmic barrel shifter for SLL, SRA and ROR by 0 to 15 places
`timescale 1ns/1ps
`default_nettype none
`include "alu_macros.svh"

module shifter import datapath_pkg::*; (
    input  logic [`ALU_WORD_W-1:0]  shift_in,
    input  logic [`ALU_SHAMT_W-1:0] shamt,
    input  shift_mode_t             mode,
    output logic [`ALU_WORD_W-1:0]  shift_out
);
    localparam int W = `ALU_WORD_W;

    // stage[i] is the word after the first i stages
    logic [`ALU_SHAMT_W:0][W-1:0] stage;

    assign stage[0] = shift_in;

    // Stage i moves the word by 2**i when shamt bit i is set
    for (genvar i = 0; i < `ALU_SHAMT_W; i++) begin : g_stage
        localparam int SH = 1 << i;

        logic [W-1:0] shifted;

        always_comb begin
            case (mode)
                SH_SLL:  shifted = {stage[i][W-1-SH:0], {SH{1'b0}}};        // Zero fill
                SH_SRA:  shifted = {{SH{stage[i][W-1]}}, stage[i][W-1:SH]}; // Sign fill
                SH_ROR:  shifted = {stage[i][SH-1:0], stage[i][W-1:SH]};    // Wrapped bits
                default: shifted = stage[i];
            endcase
        end

        assign stage[i+1] = shamt[i] ? shifted : stage[i];
    end

    assign shift_out = stage[`ALU_SHAMT_W];

endmodule

`default_nettype wire

// ==== verilog/adder_multifunc.sv ====
// Multifunction adder: saturating add/sub, nibble-wise saturating add, byte reduction
`timescale 1ns/1ps
`default_nettype none
`include "alu_macros.svh"

module adder_multifunc import datapath_pkg::*; (
    input  logic [`ALU_WORD_W-1:0] a,
    input  logic [`ALU_WORD_W-1:0] b,
    input  adder_mode_t            mode,
    output logic [`ALU_WORD_W-1:0] s,
    output logic                   ovfl
);
    localparam int W     = `ALU_WORD_W;
    localparam int BW    = `ALU_BYTE_W;
    localparam int NW    = `ALU_NIBBLE_W;
    localparam int LANES = W / NW;

    logic         sub;
    logic [W-1:0] b_eff;
    logic [W-1:0] sum;
    logic         sum_ovfl;
    logic [W-1:0] sat_sum;
    logic [W-1:0] padd_sum;
    logic [BW:0]  red_hi;
    logic [BW:0]  red_lo;
    logic [BW+1:0] red_total;
    logic [W-1:0] red_sum;

    // Shared carry chain, subtract as a + ~b + 1
    assign sub   = (mode == SUB_SAT);
    assign b_eff = sub ? ~b : b;
    assign sum   = a + b_eff + {{(W-1){1'b0}}, sub};

    // Operands agree in sign but the sum does not
    assign sum_ovfl = (a[W-1] == b_eff[W-1]) && (sum[W-1] != a[W-1]);

    always_comb begin
        if (!sum_ovfl) begin
            sat_sum = sum;
        end else if (a[W-1]) begin
            sat_sum = {1'b1, {(W-1){1'b0}}};  // Clamp to 8000
        end else begin
            sat_sum = {1'b0, {(W-1){1'b1}}};  // Clamp to 7FFF
        end
    end

    // Independent signed 4-bit lanes, no carry between them
    for (genvar i = 0; i < LANES; i++) begin : g_lane
        logic [NW-1:0] na;
        logic [NW-1:0] nb;
        logic [NW-1:0] ns;
        logic          lane_ovfl;

        assign na        = a[i*NW +: NW];
        assign nb        = b[i*NW +: NW];
        assign ns        = na + nb;
        assign lane_ovfl = (na[NW-1] == nb[NW-1]) && (ns[NW-1] != na[NW-1]);

        assign padd_sum[i*NW +: NW] = !lane_ovfl ? ns :
                                      na[NW-1]   ? {1'b1, {(NW-1){1'b0}}} :
                                                   {1'b0, {(NW-1){1'b1}}};
    end

    // Byte pair sums, each sign-extended by one bit
    assign red_hi = {a[W-1], a[W-1 -: BW]} + {b[W-1], b[W-1 -: BW]};
    assign red_lo = {a[BW-1], a[BW-1:0]} + {b[BW-1], b[BW-1:0]};

    assign red_total = {red_hi[BW], red_hi} + {red_lo[BW], red_lo};
    assign red_sum   = {{(W-BW-2){red_total[BW+1]}}, red_total};

    always_comb begin
        case (mode)
            ADD_SAT:     s = sat_sum;
            SUB_SAT:     s = sat_sum;
            PADD_NIBBLE: s = padd_sum;
            RED_BYTE:    s = red_sum;
            default:     s = sat_sum;
        endcase
    end

    // Only the word add and subtract report overflow
    assign ovfl = sum_ovfl && ((mode == ADD_SAT) || (mode == SUB_SAT));

endmodule

`default_nettype wire

// ==== verilog/datapath_pkg.sv ====
// Datapath control encodings for the multifunction adder and the shifter
`default_nettype none

package datapath_pkg;

    typedef enum logic [1:0] {
        ADD_SAT     = 2'b00,  // ADD, LW, SW
        SUB_SAT     = 2'b01,
        PADD_NIBBLE = 2'b10,
        RED_BYTE    = 2'b11
    } adder_mode_t;

    // Fourth code is unused
    typedef enum logic [1:0] {
        SH_SLL = 2'b00,  // Zero fill
        SH_SRA = 2'b01,  // Sign fill
        SH_ROR = 2'b10   // Wrap-around fill
    } shift_mode_t;

endpackage

`default_nettype wire

// ==== verilog/isa_pkg.sv ====
// Instruction set definitions: opcode encoding and flag bit positions
`default_nettype none

package isa_pkg;

    typedef enum logic [3:0] {
        OP_ADD    = 4'h0,  // Saturating add
        OP_SUB    = 4'h1,  // Saturating rs - rt
        OP_XOR    = 4'h2,
        OP_RED    = 4'h3,  // Byte reduction
        OP_SLL    = 4'h4,
        OP_SRA    = 4'h5,
        OP_ROR    = 4'h6,
        OP_PADDSB = 4'h7,  // Nibble-wise saturating add
        OP_LW     = 4'h8,  // Address add
        OP_SW     = 4'h9,  // Address add
        OP_LLB    = 4'hA,  // Load low byte
        OP_LHB    = 4'hB   // Load high byte
    } alu_op_t;

    // Bit positions inside every 3-bit flag vector
    localparam int FLAG_N = 2;
    localparam int FLAG_V = 1;
    localparam int FLAG_Z = 0;

endpackage

`default_nettype wire

// ==== verilog/alu_macros.svh ====
// ALU width constants shared by the datapath blocks and the testbench
`ifndef ALU_MACROS_SVH
`define ALU_MACROS_SVH

// Data word carried by the register operands and the result
`define ALU_WORD_W 16

// Byte lane for LLB, LHB and RED
`define ALU_BYTE_W 8

// One PADDSB lane
`define ALU_NIBBLE_W 4

// Shift amount comes from the low bits of rt
`define ALU_SHAMT_W 4

// Result for opcodes C to F
`define ALU_BAD_RESULT 16'hDEAD

`endif
